// File: all.f
+incdir+design
design/limn_pkg.sv
design/limn_control.sv
design/limn_regfile.sv
design/limn_alu.sv
design/limn_branch.sv
design/limn_lsu.sv
design/limn_core.sv
verification/limn_tb.sv

// File: design/limn_alu.sv
`timescale 1ns/1ps

module limn_alu (
    input  limn_pkg::inst_u       ir,
    input  limn_pkg::inst_class_e iclass,
    input  limn_pkg::word_t       r2_data,
    input  limn_pkg::word_t       r3_data,
    output limn_pkg::word_t       alu_result
);

    // Third operand shifter
    function automatic limn_pkg::word_t shift_op(
        input limn_pkg::word_t       a,
        input logic [4:0]            amt,
        input limn_pkg::shift_mode_e mode
    );
        logic [63:0] dbl;
        dbl = {a, a} >> amt;
        case (mode)
            limn_pkg::sh_left:  return a << amt;
            limn_pkg::sh_right: return a >> amt;
            limn_pkg::sh_arith: return limn_pkg::word_t'($signed(a) >>> amt);
            default:            return dbl[31:0]; // Rotate right
        endcase
    endfunction

    function automatic limn_pkg::word_t alu_fn(
        input limn_pkg::alu_op_e op,
        input limn_pkg::word_t   a,
        input limn_pkg::word_t   b
    );
        case (op)
            limn_pkg::alu_add:  return a + b;
            limn_pkg::alu_sub:  return a - b;
            limn_pkg::alu_and:  return a & b;
            limn_pkg::alu_xor:  return a ^ b;
            limn_pkg::alu_or:   return a | b;
            limn_pkg::alu_slt:  return limn_pkg::word_t'(a < b);
            limn_pkg::alu_slts: return limn_pkg::word_t'($signed(a) < $signed(b));
            default:            return a | (b << 16); // LUI
        endcase
    endfunction

    limn_pkg::word_t imm_zx;
    limn_pkg::word_t shifted;

    assign imm_zx  = {16'h0, ir.i_fmt.imm16};
    assign shifted = shift_op(r3_data, ir.r_fmt.shamt,
                              limn_pkg::shift_mode_e'(ir.r_fmt.funct[1:0]));

    always_comb begin
        if (iclass == limn_pkg::cls_reg_alu) begin
            if (ir.r_fmt.funct[5:2] == 4'b0000) begin
                alu_result = ~(r2_data | shifted); // NOR
            end else begin
                alu_result = alu_fn(limn_pkg::alu_op_e'(ir.r_fmt.funct[4:2]), r2_data, shifted);
            end
        end else begin
            alu_result = alu_fn(limn_pkg::alu_op_e'(ir.i_fmt.opcode[5:3]), r2_data, imm_zx);
        end
    end

endmodule

// File: design/limn_branch.sv
`timescale 1ns/1ps

module limn_branch (
    input  limn_pkg::inst_u       ir,
    input  limn_pkg::inst_class_e iclass,
    input  limn_pkg::word_t       pc,
    input  limn_pkg::word_t       r1_data,
    output logic                  taken,
    output limn_pkg::word_t       target
);

    limn_pkg::word_t rel_target;
    limn_pkg::word_t abs_target;
    logic            cond;

    // imm21 is a signed word offset
    assign rel_target = pc + {{9{ir.b_fmt.imm21[20]}}, ir.b_fmt.imm21, 2'b00};
    assign abs_target = {pc[31], ir.j_fmt.imm29, 2'b00}; // Stays in the pc half

    // Opcode bits 4:3 tell the three branches apart
    always_comb begin
        case (ir.b_fmt.opcode[4:3])
            2'b11:   cond = (r1_data == '0);  // BEQ
            2'b10:   cond = (r1_data != '0);  // BNE
            default: cond = r1_data[31];      // BLT
        endcase
    end

    assign target = (iclass == limn_pkg::cls_jal) ? abs_target : rel_target;

    always_comb begin
        case (iclass)
            limn_pkg::cls_jal:    taken = 1'b1;
            limn_pkg::cls_branch: taken = cond;
            default:              taken = 1'b0;
        endcase
    end

endmodule

// File: design/limn_cfg.svh
`ifndef LIMN_CFG_SVH
`define LIMN_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Core dimensions
////////////////////////////////////////////////////////////////////////////

// Data and address word width
`define LIMN_XLEN 32

// Integer register count including r0
`define LIMN_NREGS 32

////////////////////////////////////////////////////////////////////////////
// Architectural constants
////////////////////////////////////////////////////////////////////////////

`define LIMN_RESET_PC 32'hFFFE0000 // First fetch address

`define LIMN_REG_LR 31 // JAL link target

`endif

// File: design/limn_control.sv
`timescale 1ns/1ps
`include "limn_cfg.svh"

module limn_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  limn_pkg::word_t       data_in,
    input  limn_pkg::word_t       alu_result,
    input  logic                  taken,
    input  limn_pkg::word_t       target,
    input  limn_pkg::word_t       mem_addr,
    input  limn_pkg::word_t       store_data,
    input  limn_pkg::word_t       load_data,
    output limn_pkg::inst_u       ir,
    output limn_pkg::inst_class_e iclass,
    output limn_pkg::word_t       pc,
    output limn_pkg::wb_t         wb,
    output limn_pkg::word_t       addr,
    output limn_pkg::word_t       data_out,
    output logic                  we,
    output logic                  ce
);

    limn_pkg::state_e state;
    limn_pkg::word_t  pc_plus4;
    limn_pkg::word_t  next_pc;

    assign pc_plus4 = pc + 32'd4;

    // Opcode decode where the first casez match wins
    always_comb begin
        casez (ir.i_fmt.opcode)
            6'b00_0000: iclass = limn_pkg::cls_nop;
            6'b11_1000: iclass = limn_pkg::cls_other; // JALR
            6'b??_?11?: iclass = limn_pkg::cls_jal;
            6'b11_1101, 6'b11_0101, 6'b10_1101: iclass = limn_pkg::cls_branch;
            6'b??_?100: iclass = limn_pkg::cls_imm_alu;
            6'b1?_?011: begin
                iclass = (ir.i_fmt.opcode[4:3] != 2'b00) ? limn_pkg::cls_load
                                                        : limn_pkg::cls_other;
            end
            6'b??_?010: begin // Only whole-word stores
                iclass = (ir.i_fmt.opcode[4:3] == limn_pkg::sz_word) ? limn_pkg::cls_store
                                                                     : limn_pkg::cls_other;
            end
            6'b11_1001: begin // Upper funct half holds the register moves
                iclass = ir.r_fmt.funct[5] ? limn_pkg::cls_other : limn_pkg::cls_reg_alu;
            end
            default: iclass = limn_pkg::cls_other;
        endcase
    end

    always_comb begin
        if (taken) begin
            next_pc = target;
        end else if (iclass == limn_pkg::cls_nop) begin
            next_pc = pc; // True no-op holds pc
        end else begin
            next_pc = pc_plus4;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Write-back select
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        wb.we    = 1'b0;
        wb.regno = ir.i_fmt.opreg1;
        wb.data  = alu_result;
        case (state)
            limn_pkg::st_execute: begin
                if (iclass == limn_pkg::cls_imm_alu || iclass == limn_pkg::cls_reg_alu) begin
                    wb.we = 1'b1;
                end else if (iclass == limn_pkg::cls_jal && ir.j_fmt.link) begin
                    wb.we    = 1'b1;
                    wb.regno = limn_pkg::regno_t'(`LIMN_REG_LR);
                    wb.data  = pc_plus4; // Link
                end
            end
            limn_pkg::st_read: begin
                wb.we   = rdy;
                wb.data = load_data;
            end
            default: ;
        endcase
        if (wb.regno == '0) begin
            wb.we = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // State machine and bus strobes
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= limn_pkg::st_fetch;
            pc    <= `LIMN_RESET_PC;
            addr  <= `LIMN_RESET_PC; // Fetch starts straight out of reset
            ce    <= 1'b1;
            we    <= 1'b0;
        end else begin
            case (state)
                limn_pkg::st_fetch: begin
                    if (rdy) begin
                        state <= limn_pkg::st_execute;
                        ce    <= 1'b0;
                    end
                end
                limn_pkg::st_execute: begin
                    pc <= next_pc;
                    ce <= 1'b1;
                    if (iclass == limn_pkg::cls_load) begin
                        state <= limn_pkg::st_read;
                        addr  <= mem_addr;
                    end else if (iclass == limn_pkg::cls_store) begin
                        state <= limn_pkg::st_write;
                        addr  <= mem_addr;
                        we    <= 1'b1;
                    end else begin
                        state <= limn_pkg::st_fetch;
                        addr  <= next_pc;
                    end
                end
                limn_pkg::st_read, limn_pkg::st_write: begin
                    if (rdy) begin
                        state <= limn_pkg::st_fetch;
                        addr  <= pc; // pc already advanced in execute
                        we    <= 1'b0;
                    end
                end
                default: state <= limn_pkg::st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == limn_pkg::st_fetch && rdy) begin
            ir <= data_in;
        end
        if (state == limn_pkg::st_execute) begin
            data_out <= store_data; // Held for the whole write
        end
    end

    a_we_with_ce: assert property (@(posedge clk) disable iff (rst) we |-> ce);

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {limn_pkg::st_fetch, limn_pkg::st_execute,
                      limn_pkg::st_read, limn_pkg::st_write});

endmodule

// File: design/limn_core.sv
`timescale 1ns/1ps

module limn_core (
    input  logic            clk,
    input  logic            rst,
    input  limn_pkg::word_t data_in,
    input  logic            rdy,
    output limn_pkg::word_t addr,
    output limn_pkg::word_t data_out,
    output logic            we,
    output logic            ce
);

    limn_pkg::inst_u       ir;
    limn_pkg::inst_class_e iclass;
    limn_pkg::word_t       pc;
    limn_pkg::wb_t         wb;
    limn_pkg::word_t       r1_data;
    limn_pkg::word_t       r2_data;
    limn_pkg::word_t       r3_data;
    limn_pkg::word_t       alu_result;
    logic                  taken;
    limn_pkg::word_t       target;
    limn_pkg::word_t       mem_addr;
    limn_pkg::word_t       store_data;
    limn_pkg::word_t       load_data;

    ////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////

    limn_control i_control (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .data_in    (data_in),
        .alu_result (alu_result),
        .taken      (taken),
        .target     (target),
        .mem_addr   (mem_addr),
        .store_data (store_data),
        .load_data  (load_data),
        .ir         (ir),
        .iclass     (iclass),
        .pc         (pc),
        .wb         (wb),
        .addr       (addr),
        .data_out   (data_out),
        .we         (we),
        .ce         (ce)
    );

    ////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////

    limn_regfile i_regfile (
        .clk     (clk),
        .rst     (rst),
        .ir      (ir),
        .wb      (wb),
        .r1_data (r1_data),
        .r2_data (r2_data),
        .r3_data (r3_data)
    );

    limn_alu i_alu (
        .ir         (ir),
        .iclass     (iclass),
        .r2_data    (r2_data),
        .r3_data    (r3_data),
        .alu_result (alu_result)
    );

    limn_branch i_branch (
        .ir      (ir),
        .iclass  (iclass),
        .pc      (pc),
        .r1_data (r1_data),
        .taken   (taken),
        .target  (target)
    );

    limn_lsu i_lsu (
        .ir         (ir),
        .iclass     (iclass),
        .r1_data    (r1_data),
        .r2_data    (r2_data),
        .data_in    (data_in), // Load word arrives here during read
        .mem_addr   (mem_addr),
        .store_data (store_data),
        .load_data  (load_data)
    );

endmodule

// File: design/limn_lsu.sv
`timescale 1ns/1ps

module limn_lsu (
    input  limn_pkg::inst_u       ir,
    input  limn_pkg::inst_class_e iclass,
    input  limn_pkg::word_t       r1_data,
    input  limn_pkg::word_t       r2_data,
    input  limn_pkg::word_t       data_in,
    output limn_pkg::word_t       mem_addr,
    output limn_pkg::word_t       store_data,
    output limn_pkg::word_t       load_data
);

    limn_pkg::xfer_size_e size;
    logic [1:0]           scale;
    limn_pkg::word_t      base;
    limn_pkg::word_t      lane;

    assign size  = limn_pkg::xfer_size_e'(ir.i_fmt.opcode[4:3]);
    assign scale = ~ir.i_fmt.opcode[4:3]; // Word offsets count in fours
    assign base  = (iclass == limn_pkg::cls_store) ? r1_data : r2_data;

    assign mem_addr = base + ({16'h0, ir.i_fmt.imm16} << scale);

    // Register source or the 5-bit immediate in the opreg2 slot
    assign store_data = ir.i_fmt.opcode[5] ? r2_data : {27'h0, ir.i_fmt.opreg2};

    ////////////////////////////////////////////////////////////////////////
    // Load lane extraction
    ////////////////////////////////////////////////////////////////////////

    assign lane = data_in >> {mem_addr[1:0], 3'b000};

    always_comb begin
        case (size)
            limn_pkg::sz_byte: load_data = {24'h0, lane[7:0]};
            limn_pkg::sz_half: begin
                load_data = {16'h0, mem_addr[1] ? data_in[31:16] : data_in[15:0]};
            end
            default:           load_data = data_in;
        endcase
    end

    // Control decodes only word stores
    always_comb begin
        if (iclass == limn_pkg::cls_store) begin
            a_store_word: assert (size == limn_pkg::sz_word);
        end
    end

endmodule

// File: design/limn_pkg.sv
`include "limn_cfg.svh"

package limn_pkg;

    typedef logic [`LIMN_XLEN-1:0] word_t;
    typedef logic [$clog2(`LIMN_NREGS)-1:0] regno_t;

    ////////////////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [15:0] imm16;
        regno_t      opreg2;    // Also the 5-bit store immediate
        regno_t      opreg1;
        logic [5:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  funct;     // Bits 1:0 pick the shift mode
        logic [4:0]  shamt;
        regno_t      opreg3;
        regno_t      opreg2;
        regno_t      opreg1;
        logic [5:0]  opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [20:0] imm21;
        regno_t      opreg1;
        logic [5:0]  opcode;
    } b_fmt_t;

    // imm29 overlaps the upper opcode bits here
    typedef struct packed {
        logic [28:0] imm29;
        logic [1:0]  jal_tag;
        logic        link;
    } j_fmt_t;

    typedef union packed {
        i_fmt_t i_fmt;
        r_fmt_t r_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    ////////////////////////////////////////////////////////////////////////
    // Decoded fields
    ////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        cls_nop, cls_imm_alu, cls_reg_alu, cls_branch,
        cls_jal, cls_load, cls_store, cls_other
    } inst_class_e;

    typedef enum logic [2:0] {
        alu_lui  = 3'b000, alu_or   = 3'b001, alu_xor = 3'b010, alu_and = 3'b011,
        alu_slts = 3'b100, alu_slt  = 3'b101, alu_sub = 3'b110, alu_add = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        sh_left = 2'b00, sh_right = 2'b01, sh_arith = 2'b10, sh_ror = 2'b11
    } shift_mode_e;

    // Offset scale is the complement of the size field
    typedef enum logic [1:0] {
        sz_word = 2'b01, sz_half = 2'b10, sz_byte = 2'b11
    } xfer_size_e;

    typedef struct packed {
        logic   we;
        regno_t regno;
        word_t  data;
    } wb_t;

    typedef enum logic [2:0] {
        st_fetch = 3'd0, st_execute = 3'd1, st_read = 3'd2, st_write = 3'd3
    } state_e;

endpackage

// File: design/limn_regfile.sv
`timescale 1ns/1ps
`include "limn_cfg.svh"

module limn_regfile (
    input  logic            clk,
    input  logic            rst,
    input  limn_pkg::inst_u ir,
    input  limn_pkg::wb_t   wb,
    output limn_pkg::word_t r1_data,
    output limn_pkg::word_t r2_data,
    output limn_pkg::word_t r3_data
);

    limn_pkg::word_t regs [`LIMN_NREGS];

    // Single write port
    always_ff @(posedge clk) begin
        if (wb.we && !rst) begin
            regs[wb.regno] <= wb.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read ports with r0 tied to zero
    ////////////////////////////////////////////////////////////////////////

    assign r1_data = (ir.r_fmt.opreg1 == '0) ? '0 : regs[ir.r_fmt.opreg1];
    assign r2_data = (ir.r_fmt.opreg2 == '0) ? '0 : regs[ir.r_fmt.opreg2];
    assign r3_data = (ir.r_fmt.opreg3 == '0) ? '0 : regs[ir.r_fmt.opreg3];

    // Control filters r0 out of write-back
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        wb.we |-> wb.regno != '0);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the limn core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module limn_tb -o limn_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/limn_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "Pass message not found"
exit 1

// File: verification/limn_tb.sv
`timescale 1ns/1ps
`include "limn_cfg.svh"

module limn_tb;

    localparam int N_INST = 400;
    localparam limn_pkg::word_t LAST_PC = `LIMN_RESET_PC + 4 * (N_INST - 1);
    // At most two transactions per instruction, up to five cycles each
    localparam longint WATCHDOG_NS = (2 * N_INST * 5 + 400) * 8;

    typedef struct packed {
        logic            we;
        logic            fetch;     // Instruction fetch, execute follows
        logic            last;      // Fetch of the final self jump
        logic [2:0]      tag;       // Behavior that the check belongs to
        limn_pkg::word_t addr;
        limn_pkg::word_t data;
    } xact_t;

    logic            clk, rst, rdy, we, ce;
    limn_pkg::word_t data_in, addr, data_out;

    integer          seed = 57948;
    limn_pkg::word_t bus_mem [limn_pkg::word_t];
    limn_pkg::word_t ref_mem [limn_pkg::word_t];
    limn_pkg::word_t ref_regs [32];
    logic [2:0]      reg_src [32];  // Behavior that last wrote each register
    limn_pkg::word_t ref_pc;
    xact_t           exp_q [$];
    int              checks [1:6];
    int              errs [1:6];
    bit              done, busy, first_fetch;
    bit              exec_due, after_exec;
    int unsigned     wait_left;
    limn_pkg::word_t held_addr, held_do;
    logic            held_we;

    limn_core i_limn_core (
        .clk      (clk),
        .rst      (rst),
        .data_in  (data_in),
        .rdy      (rdy),
        .addr     (addr),
        .data_out (data_out),
        .we       (we),
        .ce       (ce)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned rnd(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Unwritten words get a value tied to the whole address
    function automatic limn_pkg::word_t fill_word(limn_pkg::word_t waddr);
        return (waddr * 32'h9E37_79B1) ^ {waddr[15:0], waddr[31:16]};
    endfunction

    function automatic limn_pkg::word_t read_mem(bit from_ref, limn_pkg::word_t waddr);
        if (from_ref) begin
            return ref_mem.exists(waddr) ? ref_mem[waddr] : fill_word(waddr);
        end
        return bus_mem.exists(waddr) ? bus_mem[waddr] : fill_word(waddr);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program generator
    ////////////////////////////////////////////////////////////////////////////

    function automatic limn_pkg::word_t jal_word(int unsigned tgt, logic link);
        limn_pkg::word_t t;
        t = `LIMN_RESET_PC + 4 * tgt;
        return {t[30:2], 2'b11, link};
    endfunction

    task automatic gen_program();
        limn_pkg::word_t ins;
        logic [4:0]      rd;
        logic [5:0]      op;
        int unsigned     tgt;
        for (int i = 0; i < N_INST; i++) begin
            rd = 5'(2 + rnd(30)); // r1 stays the data base
            if (i < 30) begin
                ins = {16'(rnd(65536)), 5'd0, 5'(i + 2), 6'b111100}; // ADD from r0
            end else if (i == 30) begin
                ins = {16'h0001, 5'd0, 5'd1, 6'b000100}; // LUI r1, data base
            end else if (i == N_INST - 1) begin
                ins = jal_word(i, 1'b0);
            end else begin
                case (rnd(10))
                    0, 1: ins = {16'(rnd(65536)), 5'(rnd(32)), rd, 3'(rnd(8)), 3'b100};
                    2, 3: begin
                        ins = {1'b0, 3'(rnd(8)), 2'(rnd(4)), 5'(rnd(32)), 5'(rnd(32)),
                               5'(rnd(32)), rd, 6'b111001};
                    end
                    4: begin
                        case (rnd(3))
                            0: ins = {16'(rnd(256)), 5'd1, rd, 6'b111011};
                            1: ins = {16'(rnd(128)), 5'd1, rd, 6'b110011};
                            default: ins = {16'(rnd(64)), 5'd1, rd, 6'b101011};
                        endcase
                    end
                    5, 6: begin
                        op = rnd(2) != 0 ? 6'b101010 : 6'b001010;
                        ins = {16'(rnd(64)), 5'(rnd(32)), 5'd1, op};
                    end
                    7: begin
                        tgt = i + 1 + rnd(4);
                        if (tgt > N_INST - 1) tgt = N_INST - 1;
                        case (rnd(3))
                            0: op = 6'h3D;
                            1: op = 6'h35;
                            default: op = 6'h2D;
                        endcase
                        ins = {21'(tgt - i), 5'(rnd(32)), op};
                    end
                    8: begin
                        tgt = i + 1 + rnd(6);
                        if (tgt > N_INST - 1) tgt = N_INST - 1;
                        ins = jal_word(tgt, 1'(rnd(2)));
                    end
                    default: ins = {26'(rnd(1 << 26)), 6'b000001}; // Unused opcode
                endcase
            end
            bus_mem[(`LIMN_RESET_PC >> 2) + i] = ins;
            ref_mem[(`LIMN_RESET_PC >> 2) + i] = ins;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // ISA model
    ////////////////////////////////////////////////////////////////////////////

    function automatic limn_pkg::word_t get_reg(logic [4:0] r);
        return (r == 5'd0) ? 32'h0 : ref_regs[r];
    endfunction

    task automatic set_reg(logic [4:0] r, limn_pkg::word_t v, logic [2:0] tag);
        if (r != 5'd0) begin
            ref_regs[r] = v;
            reg_src[r]  = tag;
        end
    endtask

    function automatic limn_pkg::word_t alu_model(logic [2:0] op, limn_pkg::word_t a,
                                                  limn_pkg::word_t b);
        case (op)
            3'd0: return a | (b << 16);
            3'd1: return a | b;
            3'd2: return a ^ b;
            3'd3: return a & b;
            3'd4: return {31'h0, $signed(a) < $signed(b)};
            3'd5: return {31'h0, a < b};
            3'd6: return a - b;
            default: return a + b;
        endcase
    endfunction

    function automatic limn_pkg::word_t shift_model(limn_pkg::word_t x, logic [4:0] n,
                                                    logic [1:0] mode);
        case (mode)
            2'd0: return x << n;
            2'd1: return x >> n;
            2'd2: return $signed(x) >>> n;
            default: return (x >> n) | (x << (6'd32 - n)); // Zero when n is 0
        endcase
    endfunction

    function automatic xact_t make_xact(logic w, logic f, logic last, logic [2:0] tag,
                                        limn_pkg::word_t a, limn_pkg::word_t d);
        xact_t x;
        x.we    = w;
        x.fetch = f;
        x.last  = last;
        x.tag   = tag;
        x.addr  = a;
        x.data  = d;
        return x;
    endfunction

    task automatic model_step();
        limn_pkg::word_t ins, ea, w, res, b, nxt;
        logic [5:0]      op;
        logic [4:0]      ra, rb;
        logic            cond;
        ins = read_mem(1'b1, ref_pc >> 2);
        op  = ins[5:0];
        ra  = ins[10:6];
        rb  = ins[15:11];
        exp_q.push_back(make_xact(1'b0, 1'b1, ref_pc == LAST_PC,
                                  first_fetch ? 3'd1 : 3'd5, ref_pc, 32'h0));
        first_fetch = 1'b0;
        nxt = ref_pc + 4;
        if (op[2:1] == 2'b11) begin // JAL
            if (ins[0]) set_reg(5'(`LIMN_REG_LR), ref_pc + 4, 3'd5);
            nxt = {ref_pc[31], ins[31:3], 2'b00};
        end else if (op == 6'h3D || op == 6'h35 || op == 6'h2D) begin
            w = get_reg(ra);
            cond = (op == 6'h3D) ? (w == 0) : (op == 6'h35) ? (w != 0) : w[31];
            if (cond) nxt = ref_pc + {{9{ins[31]}}, ins[31:11], 2'b00};
        end else if (op[2:0] == 3'b100) begin
            set_reg(ra, alu_model(op[5:3], get_reg(rb), {16'h0, ins[31:16]}), 3'd2);
        end else if (op == 6'h39) begin
            b = shift_model(get_reg(ins[20:16]), ins[25:21], ins[27:26]);
            res = (ins[30:28] == 3'd0) ? ~(get_reg(rb) | b)
                                       : alu_model(ins[30:28], get_reg(rb), b);
            set_reg(ra, res, 3'd3);
        end else if (op == 6'h3B || op == 6'h33 || op == 6'h2B) begin
            ea = get_reg(rb) + ({16'h0, ins[31:16]} << ((op == 6'h3B) ? 0 :
                                                        (op == 6'h33) ? 1 : 2));
            w = read_mem(1'b1, ea >> 2);
            if (op == 6'h3B) res = {24'h0, 8'(w >> {ea[1:0], 3'b000})};
            else if (op == 6'h33) res = {16'h0, ea[1] ? w[31:16] : w[15:0]};
            else res = w;
            exp_q.push_back(make_xact(1'b0, 1'b0, 1'b0, 3'd4, ea, 32'h0));
            set_reg(ra, res, 3'd4);
        end else if (op == 6'h0A || op == 6'h2A) begin
            ea = get_reg(ra) + ({16'h0, ins[31:16]} << 2);
            w  = op[5] ? get_reg(rb) : {27'h0, rb};
            ref_mem[ea >> 2] = w;
            exp_q.push_back(make_xact(1'b1, 1'b0, 1'b0, op[5] ? reg_src[rb] : 3'd4, ea, w));
        end
        ref_pc = nxt;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks and bus
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_addr(string name, limn_pkg::word_t act, limn_pkg::word_t exp,
                              logic [2:0] tag);
        checks[tag]++;
        if (act !== exp) begin
            errs[tag]++;
            $display("FAIL time %0t %s actual %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_store_data(string name, limn_pkg::word_t act,
                                    limn_pkg::word_t exp, logic [2:0] tag);
        checks[tag]++;
        if (act !== exp) begin
            errs[tag]++;
            $display("FAIL time %0t %s actual %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_we(logic act, logic exp, logic [2:0] tag);
        checks[tag]++;
        if (act !== exp) begin
            errs[tag]++;
            $display("FAIL time %0t we actual %b expected %b", $time, act, exp);
        end
    endtask

    task automatic check_ce(logic act, logic exp, logic [2:0] tag);
        checks[tag]++;
        if (act !== exp) begin
            errs[tag]++;
            $display("FAIL time %0t ce actual %b expected %b", $time, act, exp);
        end
    endtask

    task automatic complete_xact();
        xact_t x;
        if (exp_q.size() == 0) model_step();
        x = exp_q.pop_front();
        check_addr("addr", addr, x.addr, x.tag);
        check_we(we, x.we, x.tag);
        if (x.we) check_store_data("data_out", data_out, x.data, x.tag);
        if (we) bus_mem[addr >> 2] = data_out;
        exec_due = x.fetch;
        if (x.last) done = 1'b1;
    endtask

    task automatic drive_bus();
        if (ce) begin
            if (!busy) begin // New transaction starts
                busy      = 1'b1;
                wait_left = rnd(4);
                held_addr = addr;
                held_do   = data_out;
                held_we   = we;
            end
            if (wait_left == 0) begin
                rdy     = 1'b1;
                data_in = read_mem(1'b0, addr >> 2);
            end else begin
                rdy = 1'b0;
                wait_left--;
            end
        end else begin
            rdy = 1'b0;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the program never reached its final jump");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        string names [1:6];
        int    total_err;
        names = '{"reset fetch", "immediate ALU", "register ALU", "loads and stores",
                  "control flow", "bus hold"};
        rst = 1'b1;
        rdy = 1'b0;
        data_in = '0;
        busy = 1'b0;
        done = 1'b0;
        exec_due = 1'b0;
        after_exec = 1'b0;
        wait_left = 0;
        first_fetch = 1'b1;
        total_err = 0;
        ref_pc = `LIMN_RESET_PC;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
            reg_src[r]  = 3'd2;
        end
        for (int t = 1; t <= 6; t++) begin
            checks[t] = 0;
            errs[t]   = 0;
        end
        gen_program();
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        check_ce(ce, 1'b1, 3'd1); // First fetch is already on the bus
        drive_bus();
        while (!done) begin
            @(negedge clk);
            if (exec_due) begin // Execute is one cycle with ce low
                check_ce(ce, 1'b0, 3'd6);
                exec_due   = 1'b0;
                after_exec = 1'b1;
            end else if (after_exec) begin
                check_ce(ce, 1'b1, 3'd6);
                after_exec = 1'b0;
            end
            if (ce && busy) begin // Outputs must hold until rdy
                check_addr("addr", addr, held_addr, 3'd6);
                check_store_data("data_out", data_out, held_do, 3'd6);
                check_we(we, held_we, 3'd6);
            end
            if (ce && rdy) begin
                complete_xact();
                busy = 1'b0;
            end
            @(posedge clk);
            #1;
            drive_bus();
        end
        for (int t = 1; t <= 6; t++) begin
            $display("Behavior %0d %s: %0d checks, %0d errors", t, names[t], checks[t], errs[t]);
            if (checks[t] == 0) begin
                $display("Behavior %0d %s was never exercised", t, names[t]);
                total_err++;
            end
            total_err += errs[t];
        end
        $display("Total errors %0d", total_err);
        if (total_err == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
